/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// Bus payload types
	typedef logic [31:0] word_t;
	typedef logic [29:0] waddr_t;
	typedef logic [3:0]  bsel_t;
	typedef logic [1:0]  pi1_op_t;
	typedef logic [1:0]  slave_idx_t;

	// Reset counter width that also bounds the testbench waits
	typedef logic [15:0] rst_cnt_t;

	// Bus op codes
	// Code 3 (swap) is not supported and acts as a NOP
	localparam pi1_op_t OP_NOP = 2'd0;
	localparam pi1_op_t OP_WR  = 2'd1;
	localparam pi1_op_t OP_RD  = 2'd2;

	// Slave slots, laid out from word 0 in this order
	localparam int SLAVE_COUNT = 3;

	localparam slave_idx_t SLV_RAM     = 2'd0;
	localparam slave_idx_t SLV_DEVTBL  = 2'd1;
	localparam slave_idx_t SLV_INVALID = 2'd2;

	// Window size of each slot in words
	localparam word_t MAP_WORDS [0:SLAVE_COUNT-1] = '{
		32'd1024,
		32'd64,
		32'd1024
	};

	// Device ids reported through the device table
	localparam word_t DEV_ID [0:SLAVE_COUNT-1] = '{
		32'd1,
		32'd7,
		32'd0
	};

	localparam word_t SOC_ID = 32'd5;

	// Device table word offsets
	localparam waddr_t DT_SOCID      = 30'd0;
	localparam waddr_t DT_RSTCTRL    = 30'd1;
	localparam waddr_t DT_COUNT      = 30'd2;
	localparam waddr_t DT_ID_BASE    = 30'd16;
	localparam waddr_t DT_MAPSZ_BASE = 30'd32;

endpackage

`default_nettype wire

/* hdl/pi1_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One request/response channel between the router and a single slave
interface pi1_if import soc_pkg::*; ();

	pi1_op_t op;
	waddr_t  addr;
	word_t   wdata;
	bsel_t   sel;

	word_t   rdata;
	logic    rdy;

	modport master (
		output op,
		output addr,
		output wdata,
		output sel,
		input  rdata,
		input  rdy
	);

	modport slave (
		input  op,
		input  addr,
		input  wdata,
		input  sel,
		output rdata,
		output rdy
	);

endinterface

`default_nettype wire

/* hdl/reset_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module reset_ctrl import soc_pkg::*; #(
	parameter int unsigned RST_HOLD = 20
) (
	input  wire  clk48mhz_i,
	input  wire  rst_p,
	input  wire  swrst0_i,
	input  wire  swrst1_i,
	output logic sys_rst_o,
	output logic pwr_off_o
);

	typedef enum logic [1:0] {
		RUN,
		HOLD,
		OFF
	} rst_state_e;

	localparam rst_cnt_t HOLD_LOAD = rst_cnt_t'(RST_HOLD);

	rst_state_e state_q;
	rst_cnt_t   cnt_q;

	// Bit 1 requests a warm reset (cold when bit 0 is also set)
	// Bit 0 alone requests power-off
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			state_q <= HOLD;
			cnt_q <= HOLD_LOAD;
		end else begin
			unique case (state_q)
				RUN: begin
					if (swrst1_i) begin
						state_q <= HOLD;
						cnt_q <= HOLD_LOAD;
					end else if (swrst0_i) begin
						state_q <= OFF;
					end
				end
				HOLD: begin
					// Restart the count while the cause is still present
					if (swrst1_i) begin
						cnt_q <= HOLD_LOAD;
					end else if (cnt_q < rst_cnt_t'(2)) begin
						state_q <= RUN;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				OFF: begin
					state_q <= OFF;  // only rst_p leaves this state
				end
				default: begin
					state_q <= HOLD;
					cnt_q <= HOLD_LOAD;
				end
			endcase
		end
	end

	assign sys_rst_o = (state_q != RUN);
	assign pwr_off_o = (state_q == OFF);

endmodule

`default_nettype wire

/* hdl/pi1_router.sv */
`timescale 1ns/1ns
`default_nettype none

module pi1_router import soc_pkg::*; (
	input  wire     clk48mhz_i,
	input  wire     rst_i,
	input  pi1_op_t m_op_i,
	input  waddr_t  m_addr_i,
	input  word_t   m_wdata_i,
	input  bsel_t   m_sel_i,
	output word_t   m_rdata_o,
	output logic    m_rdy_o,
	pi1_if.master   ram_bus,
	pi1_if.master   devtbl_bus
);

	// Window bounds derived from the map table
	localparam waddr_t DT_LO = waddr_t'(MAP_WORDS[SLV_RAM]);
	localparam waddr_t DT_HI = DT_LO + waddr_t'(MAP_WORDS[SLV_DEVTBL]);

	slave_idx_t dec_slot;
	waddr_t     dec_base;
	pi1_op_t    req_op;
	logic       accept;

	slave_idx_t slot_q;
	logic       live_q;
	logic       slot_rdy;
	word_t      slot_rdata;

	// Address decode
	always_comb begin
		if (m_addr_i < DT_LO) begin
			dec_slot = SLV_RAM;
			dec_base = '0;
		end else if (m_addr_i < DT_HI) begin
			dec_slot = SLV_DEVTBL;
			dec_base = DT_LO;
		end else begin
			dec_slot = SLV_INVALID;
			dec_base = '0;
		end
	end

	// Unsupported op codes behave as no request
	assign req_op = (m_op_i == OP_WR || m_op_i == OP_RD) ? m_op_i : OP_NOP;
	assign accept = (req_op != OP_NOP) && m_rdy_o;

	// Only the addressed slave sees the op
	assign ram_bus.op    = (accept && dec_slot == SLV_RAM) ? req_op : OP_NOP;
	assign ram_bus.addr  = m_addr_i - dec_base;
	assign ram_bus.wdata = m_wdata_i;
	assign ram_bus.sel   = m_sel_i;

	assign devtbl_bus.op    = (accept && dec_slot == SLV_DEVTBL) ? req_op : OP_NOP;
	assign devtbl_bus.addr  = m_addr_i - dec_base;
	assign devtbl_bus.wdata = m_wdata_i;
	assign devtbl_bus.sel   = m_sel_i;

	// Slot of the request in flight that the response comes back from
	always_ff @(posedge clk48mhz_i) begin
		if (rst_i) begin
			slot_q <= SLV_INVALID;
			live_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (accept) begin
				slot_q <= dec_slot;
			end
		end
	end

	// Response mux with the invalid device always ready and reading zero
	always_comb begin
		unique case (slot_q)
			SLV_RAM: begin
				slot_rdy = ram_bus.rdy;
				slot_rdata = ram_bus.rdata;
			end
			SLV_DEVTBL: begin
				slot_rdy = devtbl_bus.rdy;
				slot_rdata = devtbl_bus.rdata;
			end
			default: begin
				slot_rdy = 1'b1;
				slot_rdata = '0;
			end
		endcase
	end

	assign m_rdy_o   = live_q && slot_rdy;
	assign m_rdata_o = slot_rdata;

endmodule

`default_nettype wire

/* hdl/devtbl.sv */
`timescale 1ns/1ns
`default_nettype none

module devtbl import soc_pkg::*; (
	input  wire   clk48mhz_i,
	input  wire   rst_i,
	output logic  swrst0_o,
	output logic  swrst1_o,
	pi1_if.slave  bus
);

	logic [1:0] rst_bits_q;
	logic       rdy_q;
	word_t      rdata_q;
	logic       rd_acc;
	logic       wr_acc;

	// Table lookup by word offset
	function automatic word_t dt_lookup(input waddr_t off, input logic [1:0] rbits);
		slave_idx_t idx;
		word_t      val;
		idx = off[$bits(slave_idx_t)-1:0];
		val = '0;
		if (off == DT_SOCID) begin
			val = SOC_ID;
		end else if (off == DT_RSTCTRL) begin
			val = {30'd0, rbits};
		end else if (off == DT_COUNT) begin
			val = word_t'(SLAVE_COUNT);
		end else if (off >= DT_ID_BASE && off < DT_ID_BASE + waddr_t'(SLAVE_COUNT)) begin
			val = DEV_ID[idx];
		end else if (off >= DT_MAPSZ_BASE &&
				off < DT_MAPSZ_BASE + waddr_t'(SLAVE_COUNT)) begin
			// Reported in bytes
			val = MAP_WORDS[idx] << 2;
		end
		return val;
	endfunction

	assign rd_acc = rdy_q && (bus.op == OP_RD);
	assign wr_acc = rdy_q && (bus.op == OP_WR);

	always_ff @(posedge clk48mhz_i) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
			rst_bits_q <= 2'b00;
		end else begin
			rdy_q <= 1'b1;
			// Reset bits live in byte lane 0
			if (wr_acc && bus.addr == DT_RSTCTRL && bus.sel[0]) begin
				rst_bits_q <= bus.wdata[1:0];
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rd_acc) begin
			rdata_q <= dt_lookup(bus.addr, rst_bits_q);
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;

	assign swrst0_o = rst_bits_q[0];
	assign swrst1_o = rst_bits_q[1];

endmodule

`default_nettype wire

/* hdl/scratch_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module scratch_ram import soc_pkg::*; #(
	parameter int unsigned RAM_WAIT = 2
) (
	input  wire   clk48mhz_i,
	input  wire   rst_i,
	pi1_if.slave  bus
);

	localparam int RAM_WORDS = int'(MAP_WORDS[SLV_RAM]);
	localparam int AW        = $clog2(RAM_WORDS);
	localparam int WCW       = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

	word_t mem [0:RAM_WORDS-1];

	logic [AW-1:0]  widx;
	logic [WCW-1:0] wait_q;
	word_t          rdata_q;
	logic           rdy;
	logic           rd_acc;
	logic           wr_acc;

	assign widx   = bus.addr[AW-1:0];
	assign rdy    = (wait_q == '0);
	assign rd_acc = rdy && (bus.op == OP_RD);
	assign wr_acc = rdy && (bus.op == OP_WR);

	// Wait states after every accepted request
	always_ff @(posedge clk48mhz_i) begin
		if (rst_i) begin
			wait_q <= '0;
		end else if (rd_acc || wr_acc) begin
			wait_q <= WCW'(RAM_WAIT);
		end else if (!rdy) begin
			wait_q <= wait_q - 1'b1;
		end
	end

	// Byte-lane merge on write
	always_ff @(posedge clk48mhz_i) begin
		if (wr_acc) begin
			for (int b = 0; b < $bits(bsel_t); b++) begin
				if (bus.sel[b]) begin
					mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	// Data is held until the next read
	always_ff @(posedge clk48mhz_i) begin
		if (rd_acc) begin
			rdata_q <= mem[widx];
		end
	end

	assign bus.rdy   = rdy;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* hdl/soc_core.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_core import soc_pkg::*; #(
	parameter int unsigned RST_HOLD = 20,
	parameter int unsigned RAM_WAIT = 2
) (
	input  wire     clk48mhz_i,
	input  wire     rst_p,
	input  pi1_op_t bus_op_i,
	input  waddr_t  bus_addr_i,
	input  word_t   bus_wdata_i,
	input  bsel_t   bus_sel_i,
	output word_t   bus_rdata_o,
	output logic    bus_rdy_o,
	output logic    pwr_off_o
);

	logic sys_rst;
	logic swrst0;
	logic swrst1;

	pi1_if ram_bus ();
	pi1_if devtbl_bus ();

	reset_ctrl #(
		.RST_HOLD (RST_HOLD)
	) reset_ctrl0 (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (rst_p),
		.swrst0_i   (swrst0),
		.swrst1_i   (swrst1),
		.sys_rst_o  (sys_rst),
		.pwr_off_o  (pwr_off_o)
	);

	pi1_router router0 (
		.clk48mhz_i (clk48mhz_i),
		.rst_i      (sys_rst),
		.m_op_i     (bus_op_i),
		.m_addr_i   (bus_addr_i),
		.m_wdata_i  (bus_wdata_i),
		.m_sel_i    (bus_sel_i),
		.m_rdata_o  (bus_rdata_o),
		.m_rdy_o    (bus_rdy_o),
		.ram_bus    (ram_bus),
		.devtbl_bus (devtbl_bus)
	);

	devtbl devtbl0 (
		.clk48mhz_i (clk48mhz_i),
		.rst_i      (sys_rst),
		.swrst0_o   (swrst0),
		.swrst1_o   (swrst1),
		.bus        (devtbl_bus)
	);

	// RAM keeps its contents across software resets
	scratch_ram #(
		.RAM_WAIT (RAM_WAIT)
	) ram0 (
		.clk48mhz_i (clk48mhz_i),
		.rst_i      (rst_p),
		.bus        (ram_bus)
	);

endmodule

`default_nettype wire

/* tb/tb_soc_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_core import soc_pkg::*; ();

	localparam int unsigned RST_HOLD = 20;
	localparam int unsigned RAM_WAIT = 2;
	localparam rst_cnt_t RST_BOUND = rst_cnt_t'(RST_HOLD + 10);
	localparam rst_cnt_t RAM_BOUND = rst_cnt_t'(RAM_WAIT + 10);
	localparam waddr_t DT_BASE = 30'd1024;
	localparam waddr_t RAM_ADDRS [0:7] = '{30'd0, 30'd1, 30'd2, 30'd3,
		30'd100, 30'd511, 30'd1022, 30'd1023};

	typedef struct packed {
		pi1_op_t op;
		waddr_t  addr;
		word_t   wdata;
		bsel_t   sel;
		word_t   exp;
	} entry_t;

	logic    clk48mhz_i;
	logic    rst_p;
	pi1_op_t bus_op_i;
	waddr_t  bus_addr_i;
	word_t   bus_wdata_i;
	bsel_t   bus_sel_i;
	word_t   bus_rdata_o;
	logic    bus_rdy_o;
	logic    pwr_off_o;

	entry_t      tbl [$];
	word_t       ref_mem [0:1023];
	logic [31:0] lfsr_q = 32'h2d86_a799;
	int          wd_cycles = 0;
	int          seg_reread;
	int          seg_post;

	soc_core #(
		.RST_HOLD (RST_HOLD),
		.RAM_WAIT (RAM_WAIT)
	) dut0 (
		.clk48mhz_i  (clk48mhz_i),
		.rst_p       (rst_p),
		.bus_op_i    (bus_op_i),
		.bus_addr_i  (bus_addr_i),
		.bus_wdata_i (bus_wdata_i),
		.bus_sel_i   (bus_sel_i),
		.bus_rdata_o (bus_rdata_o),
		.bus_rdy_o   (bus_rdy_o),
		.pwr_off_o   (pwr_off_o)
	);

	initial begin
		clk48mhz_i = 1'b0;
		forever #50 clk48mhz_i = ~clk48mhz_i;
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Inputs change 5 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk48mhz_i);
		#5;
	endtask

	task automatic wait_rdy(input logic level, input rst_cnt_t bound, input string what);
		int n;
		n = 0;
		while (bus_rdy_o !== level) begin
			if (n >= bound) begin
				$display("Timeout: bus_rdy_o did not go to %b while waiting for %s", level, what);
				abort_run();
			end
			next_cycle();
			n++;
		end
	endtask

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[31]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic add_entry(input pi1_op_t op, input waddr_t addr, input word_t wdata,
			input bsel_t sel, input word_t exp);
		entry_t e;
		e.op = op;
		e.addr = addr;
		e.wdata = wdata;
		e.sel = sel;
		e.exp = exp;
		tbl.push_back(e);
	endtask

	// Random data and lanes merged into the reference copy
	task automatic add_ram_write(input waddr_t addr, input logic full);
		word_t data;
		word_t bits;
		word_t w;
		bsel_t sel;
		take_bits(32, data);
		take_bits(4, bits);
		sel = full ? 4'hf : bits[3:0];
		w = ref_mem[addr];
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				w[8*b +: 8] = data[8*b +: 8];
		end
		ref_mem[addr] = w;
		add_entry(OP_WR, addr, data, sel, '0);
	endtask

	task automatic build_tables();
		// Full words first so that no lane is left undefined
		for (int i = 0; i < 8; i++)
			add_ram_write(RAM_ADDRS[i], 1'b1);
		for (int i = 0; i < 8; i++)
			add_ram_write(RAM_ADDRS[i], 1'b0);
		for (int i = 0; i < 8; i++)
			add_entry(OP_RD, RAM_ADDRS[i], '0, 4'hf, ref_mem[RAM_ADDRS[i]]);
		add_entry(OP_RD, DT_BASE + 30'd0, '0, 4'hf, 32'd5);
		add_entry(OP_RD, DT_BASE + 30'd1, '0, 4'hf, 32'd0);
		add_entry(OP_RD, DT_BASE + 30'd2, '0, 4'hf, 32'd3);
		add_entry(OP_RD, DT_BASE + 30'd3, '0, 4'hf, 32'd0);
		add_entry(OP_RD, DT_BASE + 30'd16, '0, 4'hf, 32'd1);
		add_entry(OP_RD, DT_BASE + 30'd17, '0, 4'hf, 32'd7);
		add_entry(OP_RD, DT_BASE + 30'd18, '0, 4'hf, 32'd0);
		add_entry(OP_RD, DT_BASE + 30'd19, '0, 4'hf, 32'd0);
		add_entry(OP_RD, DT_BASE + 30'd32, '0, 4'hf, 32'd4096);
		add_entry(OP_RD, DT_BASE + 30'd33, '0, 4'hf, 32'd256);
		add_entry(OP_RD, DT_BASE + 30'd34, '0, 4'hf, 32'd4096);
		add_entry(OP_RD, DT_BASE + 30'd63, '0, 4'hf, 32'd0);
		// Unmapped space drops writes and reads zero
		add_entry(OP_WR, 30'd1088, 32'hdead_beef, 4'hf, '0);
		add_entry(OP_RD, 30'd1088, '0, 4'hf, 32'd0);
		add_entry(OP_WR, 30'd5000, 32'h1234_5678, 4'h3, '0);
		add_entry(OP_RD, 30'd5000, '0, 4'hf, 32'd0);
		add_entry(OP_WR, 30'h3fff_ffff, 32'hffff_ffff, 4'hf, '0);
		add_entry(OP_RD, 30'h3fff_ffff, '0, 4'hf, 32'd0);
		seg_reread = tbl.size();
		for (int i = 0; i < 8; i++)
			add_entry(OP_RD, RAM_ADDRS[i], '0, 4'hf, ref_mem[RAM_ADDRS[i]]);
		seg_post = tbl.size();
		add_entry(OP_RD, DT_BASE + 30'd0, '0, 4'hf, 32'd5);
		add_ram_write(30'd7, 1'b1);
		add_ram_write(30'd7, 1'b0);
		add_entry(OP_RD, 30'd7, '0, 4'hf, ref_mem[30'd7]);
	endtask

	task automatic bus_xfer(input pi1_op_t op, input waddr_t addr, input word_t wdata,
			input bsel_t sel, output word_t rdata, output logic rdy_after);
		wait_rdy(1'b1, RAM_BOUND, "the bus to accept a request");
		bus_op_i = op;
		bus_addr_i = addr;
		bus_wdata_i = wdata;
		bus_sel_i = sel;
		next_cycle();
		bus_op_i = OP_NOP;
		rdy_after = bus_rdy_o;
		wait_rdy(1'b1, RAM_BOUND, "the response to a request");
		rdata = bus_rdata_o;
	endtask

	task automatic run_table(input int first, input int last);
		entry_t e;
		word_t  rd;
		logic   ra;
		for (int i = first; i < last; i++) begin
			e = tbl[i];
			bus_xfer(e.op, e.addr, e.wdata, e.sel, rd, ra);
			if (e.op == OP_RD)
				check_word($sformatf("entry %0d read of word 0x%0h", i, e.addr), rd, e.exp);
			// Only the RAM inserts wait states
			if (e.addr >= DT_BASE)
				check_bit($sformatf("entry %0d bus_rdy_o after request", i), ra, 1'b1);
			else if (RAM_WAIT > 0)
				check_bit($sformatf("entry %0d RAM wait state", i), ra, 1'b0);
		end
	endtask

	task automatic apply_reset();
		rst_p = 1'b1;
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			if (i > 0) begin
				check_bit("bus_rdy_o during reset", bus_rdy_o, 1'b0);
				check_bit("pwr_off_o during reset", pwr_off_o, 1'b0);
			end
		end
		rst_p = 1'b0;
		wait_rdy(1'b1, RST_BOUND, "bus_rdy_o after reset");
		check_bit("pwr_off_o after reset", pwr_off_o, 1'b0);
	endtask

	task automatic sw_reset(input word_t bits);
		word_t rd;
		logic  ra;
		bus_xfer(OP_WR, DT_BASE + 30'd1, bits, 4'h1, rd, ra);
		wait_rdy(1'b0, 2, "bus_rdy_o to drop after a software reset");
		wait_rdy(1'b1, RST_BOUND, "bus_rdy_o to return after a software reset");
		check_bit("pwr_off_o after software reset", pwr_off_o, 1'b0);
		bus_xfer(OP_RD, DT_BASE + 30'd1, '0, 4'hf, rd, ra);
		check_word("reset control word after software reset", rd, 32'd0);
	endtask

	task automatic power_off();
		word_t rd;
		logic  ra;
		int    n;
		bus_xfer(OP_WR, DT_BASE + 30'd1, 32'h1, 4'h1, rd, ra);
		n = 0;
		while (pwr_off_o !== 1'b1) begin
			if (n >= 2) begin
				$display("pwr_off_o did not rise after a power-off request");
				abort_run();
			end
			next_cycle();
			n++;
		end
		wait_rdy(1'b0, 2, "bus_rdy_o to drop after a power-off request");
		// Stays off well beyond the reset hold time
		repeat (RST_HOLD + 5) begin
			next_cycle();
			check_bit("bus_rdy_o while powered off", bus_rdy_o, 1'b0);
			check_bit("pwr_off_o while powered off", pwr_off_o, 1'b1);
		end
	endtask

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk48mhz_i);
		$display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		abort_run();
	end

	initial begin
		rst_p = 1'b1;
		bus_op_i = OP_NOP;
		bus_addr_i = '0;
		bus_wdata_i = '0;
		bus_sel_i = '0;
		build_tables();
		// Table entries plus four reset sequences, the power-off hold and direct transfers
		wd_cycles = tbl.size() * (RAM_WAIT + 4) + 4 * (3 + RST_HOLD + 10) + RST_HOLD + 5
			+ 8 * (RAM_WAIT + 4);
		apply_reset();
		run_table(0, seg_reread);
		sw_reset(32'h2);
		sw_reset(32'h3);
		run_table(seg_reread, seg_post);
		power_off();
		apply_reset();
		run_table(seg_post, tbl.size());
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hdl/soc_pkg.sv
hdl/pi1_if.sv
hdl/reset_ctrl.sv
hdl/pi1_router.sv
hdl/devtbl.sv
hdl/scratch_ram.sv
hdl/soc_core.sv
tb/tb_soc_core.sv

/* Bender.yml */
package:
  name: soc_core

dependencies: {}

sources:
  - hdl/soc_pkg.sv
  - hdl/pi1_if.sv
  - hdl/reset_ctrl.sv
  - hdl/pi1_router.sv
  - hdl/devtbl.sv
  - hdl/scratch_ram.sv
  - hdl/soc_core.sv
  - target: simulation
    files:
      - tb/tb_soc_core.sv
